// File: cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;

	// Address the fetch unit wants now.
	typedef struct packed {
		logic valid;
		addr_t addr;
	} fetch_req_t;

	// Cache answer, tagged with the address it belongs to.
	typedef struct packed {
		logic ready;
		addr_t addr;
		word_t word;
	} fetch_rsp_t;

	// Instruction handed to decode.
	typedef struct packed {
		logic valid;
		addr_t addr;
		word_t word;
	} fetch_out_t;

	typedef struct packed {
		logic valid;
		addr_t target;
	} redirect_t;

endpackage

`default_nettype wire

// File: wb_bus_pkg.sv
`default_nettype none

package wb_bus_pkg;

	// Refill request from the cache, held until done.
	typedef struct packed {
		logic valid;
		cpu_types_pkg::addr_t addr;
	} bus_req_t;

	// One cycle pulse at the end of a refill.
	typedef struct packed {
		logic done;
		cpu_types_pkg::word_t word;
	} bus_rsp_t;

	// Wishbone classic signals from master to slave.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [3:0] sel;
		cpu_types_pkg::addr_t adr;
		cpu_types_pkg::word_t dat_w;
	} wb_m2s_t;

	// Wishbone classic signals from slave to master.
	typedef struct packed {
		logic ack;
		cpu_types_pkg::word_t dat_r;
	} wb_s2m_t;

endpackage

`default_nettype wire

// File: fetch_pc_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_pc_unit #(
	parameter cpu_types_pkg::addr_t RESET_PC = 32'h0000_0000
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_stall,
	input cpu_types_pkg::redirect_t i_redirect,
	output cpu_types_pkg::fetch_req_t o_req,
	input cpu_types_pkg::fetch_rsp_t i_rsp,
	output cpu_types_pkg::fetch_out_t o_fetch
);
	import cpu_types_pkg::*;

	addr_t pc;
	logic running;
	logic accept;
	logic fetch_valid;
	addr_t fetch_addr;
	word_t fetch_word;

	// The request drops while decode stalls but keeps its address.
	assign o_req = '{
		valid: running & ~i_stall,
		addr: pc
	};

	// Only an answer for the current PC counts.
	assign accept = running & i_rsp.ready & ~i_stall & ~i_redirect.valid
		& (i_rsp.addr == pc);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pc <= RESET_PC;
			running <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			running <= 1'b1;
			fetch_valid <= accept;
			if (i_redirect.valid) begin
				pc <= i_redirect.target;
			end else if (accept) begin
				pc <= pc + 32'd4;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			fetch_addr <= i_rsp.addr;
			fetch_word <= i_rsp.word;
		end
	end

	assign o_fetch = '{
		valid: fetch_valid,
		addr: fetch_addr,
		word: fetch_word
	};

endmodule

`default_nettype wire

// File: icache.sv
`timescale 1ns/1ns
`default_nettype none

module icache #(
	parameter int INDEX_BITS = 6
) (
	input logic i_clock,
	input logic i_reset,
	input cpu_types_pkg::fetch_req_t i_req,
	output cpu_types_pkg::fetch_rsp_t o_rsp,
	output wb_bus_pkg::bus_req_t o_bus_req,
	input wb_bus_pkg::bus_rsp_t i_bus_rsp
);
	import cpu_types_pkg::*;

	localparam int LINES = 1 << INDEX_BITS;
	localparam int TAG_BITS = 30 - INDEX_BITS;

	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [TAG_BITS-1:0] tag_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
		word_t word;
	} line_t;

	typedef enum logic [1:0] {
		ST_CLEAR,
		ST_IDLE,
		ST_LOOKUP,
		ST_REFILL
	} state_t;

	state_t state;
	state_t state_next;
	index_t clear_idx;
	addr_t refill_addr;
	logic start_refill;

	line_t lines [LINES];
	line_t rd_line;
	addr_t rd_addr;
	addr_t rd_addr_q;
	logic addr_match;
	logic line_hit;

	logic wr_en;
	index_t wr_index;
	line_t wr_line;

	// The two low bits of a word address are not part of the index.
	function automatic index_t index_of(input addr_t addr);
		return addr[INDEX_BITS+1:2];
	endfunction

	function automatic tag_t tag_of(input addr_t addr);
		return addr[31:INDEX_BITS+2];
	endfunction

	// The line read last cycle must belong to the address asked for now.
	assign addr_match = (rd_addr_q == i_req.addr);
	assign line_hit = rd_line.valid & (rd_line.tag == tag_of(i_req.addr));

	always_comb begin
		state_next = state;
		rd_addr = i_req.addr;
		wr_en = 1'b0;
		wr_index = clear_idx;
		wr_line = '0;
		start_refill = 1'b0;
		o_rsp = '{ready: 1'b0, addr: i_req.addr, word: rd_line.word};

		case (state)
			ST_CLEAR: begin
				wr_en = 1'b1;
				if (clear_idx == '1) begin
					state_next = ST_IDLE;
				end
			end

			ST_IDLE: begin
				if (i_req.valid) begin
					state_next = ST_LOOKUP;
				end
			end

			ST_LOOKUP: begin
				if (!i_req.valid) begin
					state_next = ST_IDLE;
				end else if (addr_match && line_hit) begin
					o_rsp.ready = 1'b1;
					// Read ahead so a sequential fetch hits next cycle.
					rd_addr = i_req.addr + 32'd4;
				end else if (addr_match) begin
					start_refill = 1'b1;
					state_next = ST_REFILL;
				end
			end

			ST_REFILL: begin
				rd_addr = refill_addr + 32'd4;
				o_rsp.addr = refill_addr;
				o_rsp.word = i_bus_rsp.word;
				if (i_bus_rsp.done) begin
					o_rsp.ready = 1'b1;
					wr_en = 1'b1;
					wr_index = index_of(refill_addr);
					wr_line = '{
						valid: 1'b1,
						tag: tag_of(refill_addr),
						word: i_bus_rsp.word
					};
					state_next = ST_LOOKUP;
				end
			end

			default: begin
				state_next = ST_CLEAR;
			end
		endcase
	end

	assign o_bus_req = '{
		valid: (state == ST_REFILL),
		addr: refill_addr
	};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_CLEAR;
			clear_idx <= '0;
		end else begin
			state <= state_next;
			if (state == ST_CLEAR) begin
				clear_idx <= clear_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (start_refill) begin
			refill_addr <= i_req.addr;
		end
	end

	// Line array with one write port and one registered read port.
	always_ff @(posedge i_clock) begin
		if (wr_en) begin
			lines[wr_index] <= wr_line;
		end
		rd_line <= lines[index_of(rd_addr)];
		rd_addr_q <= rd_addr;
	end

endmodule

`default_nettype wire

// File: wb_fetch_master.sv
`timescale 1ns/1ns
`default_nettype none

module wb_fetch_master (
	input logic i_clock,
	input logic i_reset,
	input wb_bus_pkg::bus_req_t i_bus_req,
	output wb_bus_pkg::bus_rsp_t o_bus_rsp,
	output wb_bus_pkg::wb_m2s_t o_wb,
	input wb_bus_pkg::wb_s2m_t i_wb
);
	import cpu_types_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_ACTIVE
	} state_t;

	state_t state;
	logic done;
	addr_t adr;
	word_t rdata;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ST_IDLE: begin
					// The request is still up in the done cycle, so skip it.
					if (i_bus_req.valid && !done) begin
						state <= ST_ACTIVE;
					end
				end

				ST_ACTIVE: begin
					if (i_wb.ack) begin
						state <= ST_IDLE;
						done <= 1'b1;
					end
				end

				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Address is captured while idle and frozen for the whole cycle.
	always_ff @(posedge i_clock) begin
		if (state == ST_IDLE) begin
			adr <= i_bus_req.addr;
		end
		if (state == ST_ACTIVE && i_wb.ack) begin
			rdata <= i_wb.dat_r;
		end
	end

	assign o_wb = '{
		cyc: (state == ST_ACTIVE),
		stb: (state == ST_ACTIVE),
		we: 1'b0,
		sel: 4'hf,
		adr: adr,
		dat_w: 32'h0000_0000
	};

	assign o_bus_rsp = '{done: done, word: rdata};

endmodule

`default_nettype wire

// File: cpu_fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_fetch_top #(
	parameter int INDEX_BITS = 6,
	parameter cpu_types_pkg::addr_t RESET_PC = 32'h0000_0000
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_stall,
	input cpu_types_pkg::redirect_t i_redirect,
	output cpu_types_pkg::fetch_out_t o_fetch,
	output wb_bus_pkg::wb_m2s_t o_wb,
	input wb_bus_pkg::wb_s2m_t i_wb
);
	import cpu_types_pkg::*;
	import wb_bus_pkg::*;

	fetch_req_t fetch_req;
	fetch_rsp_t fetch_rsp;
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;

	fetch_pc_unit #(
		.RESET_PC(RESET_PC)
	) i_fetch_pc_unit (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall(i_stall),
		.i_redirect(i_redirect),
		.o_req(fetch_req),
		.i_rsp(fetch_rsp),
		.o_fetch(o_fetch)
	);

	icache #(
		.INDEX_BITS(INDEX_BITS)
	) i_icache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req(fetch_req),
		.o_rsp(fetch_rsp),
		.o_bus_req(bus_req),
		.i_bus_rsp(bus_rsp)
	);

	wb_fetch_master i_wb_fetch_master (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus_req(bus_req),
		.o_bus_rsp(bus_rsp),
		.o_wb(o_wb),
		.i_wb(i_wb)
	);

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 10,
	parameter int RESET_CYCLES = 4
) (
	output logic o_clock,
	output logic o_reset
);

	initial begin
		o_clock = 1'b0;
		forever begin
			#(PERIOD / 2) o_clock = ~o_clock;
		end
	end

	// Reset drops on a falling edge, like every other input.
	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		@(negedge o_clock);
		o_reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: tb_wb_memory.sv
`timescale 1ns/1ns
`default_nettype none

module tb_wb_memory #(
	parameter logic [31:0] SEED = 32'hc2e5_c373
) (
	input logic i_clock,
	input logic i_reset,
	input wb_bus_pkg::wb_m2s_t i_wb,
	output wb_bus_pkg::wb_s2m_t o_wb,
	output logic [31:0] o_ack_count
);
	import cpu_types_pkg::*;

	logic [31:0] lfsr;
	logic [31:0] lfsr_one;
	logic [1:0] wait_pick;
	logic [1:0] wait_left;
	logic waiting;
	logic finish;
	logic ack;
	word_t dat_r;

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	// Two bits per access give 0 to 3 wait states.
	assign lfsr_one = lfsr_step(lfsr);
	assign wait_pick = {lfsr_one[0], lfsr[0]};

	assign finish = i_wb.cyc & i_wb.stb & ~ack
		& (waiting ? (wait_left == 2'd0) : (wait_pick == 2'd0));

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			lfsr <= SEED;
			waiting <= 1'b0;
			wait_left <= 2'd0;
			ack <= 1'b0;
			o_ack_count <= 32'd0;
		end else begin
			ack <= finish;
			if (finish) begin
				o_ack_count <= o_ack_count + 32'd1;
				waiting <= 1'b0;
			end else if (i_wb.cyc && i_wb.stb && !ack) begin
				if (!waiting) begin
					lfsr <= lfsr_step(lfsr_one);
					waiting <= 1'b1;
					wait_left <= wait_pick - 2'd1;
				end else begin
					wait_left <= wait_left - 2'd1;
				end
			end
			// A zero wait access still uses up its two bits.
			if (finish && !waiting) begin
				lfsr <= lfsr_step(lfsr_one);
			end
		end
	end

	always_ff @(posedge i_clock) begin
		dat_r <= i_wb.adr ^ 32'h5a5a_0000;
	end

	assign o_wb = '{ack: ack, dat_r: dat_r};

endmodule

`default_nettype wire

// File: cpu_fetch_props.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_fetch_props (
	input logic i_clock,
	input logic i_reset,
	input logic i_stall,
	input cpu_types_pkg::fetch_out_t i_fetch,
	input wb_bus_pkg::wb_m2s_t i_wb_m2s,
	input wb_bus_pkg::wb_s2m_t i_wb_s2m
);

	int failures = 0;

	stb_within_cyc: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_wb_m2s.stb |-> i_wb_m2s.cyc
	) else begin
		$error("Wishbone stb high without cyc.");
		failures++;
	end

	// Instruction fetch only reads, always with all byte lanes.
	read_all_lanes: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_wb_m2s.stb |-> (!i_wb_m2s.we && (i_wb_m2s.sel == 4'hf))
	) else begin
		$error("Wishbone cycle is not a full word read.");
		failures++;
	end

	// In a classic cycle the address holds until the slave acks.
	adr_held_until_ack: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(i_wb_m2s.stb && !i_wb_s2m.ack) |=> $stable(i_wb_m2s.adr)
	) else begin
		$error("Wishbone adr changed before ack.");
		failures++;
	end

	no_fetch_after_stall: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_stall |=> !i_fetch.valid
	) else begin
		$error("Fetch output valid one clock after a stall.");
		failures++;
	end

endmodule

bind cpu_fetch_top cpu_fetch_props i_cpu_fetch_props (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_stall(i_stall),
	.i_fetch(o_fetch),
	.i_wb_m2s(o_wb),
	.i_wb_s2m(i_wb)
);

`default_nettype wire

// File: tb_cpu_fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_fetch_top;
	import cpu_types_pkg::*;
	import wb_bus_pkg::*;

	localparam int TIMEOUT = 200;

	logic clock;
	logic reset;
	logic stall;
	redirect_t redirect;
	fetch_out_t fetch;
	wb_m2s_t wb_m2s;
	wb_s2m_t wb_s2m;
	logic [31:0] ack_count;
	logic [31:0] lfsr;
	logic hung;
	int errors;
	int checks;
	int tests;

	tb_clock_gen #(
		.PERIOD(10),
		.RESET_CYCLES(4)
	) i_clock_gen (
		.o_clock(clock),
		.o_reset(reset)
	);

	cpu_fetch_top #(
		.INDEX_BITS(4),
		.RESET_PC(32'h0000_0000)
	) i_cpu_fetch_top (
		.i_clock(clock),
		.i_reset(reset),
		.i_stall(stall),
		.i_redirect(redirect),
		.o_fetch(fetch),
		.o_wb(wb_m2s),
		.i_wb(wb_s2m)
	);

	tb_wb_memory #(
		.SEED(32'hc2e5_c373)
	) i_memory (
		.i_clock(clock),
		.i_reset(reset),
		.i_wb(wb_m2s),
		.o_wb(wb_s2m),
		.o_ack_count(ack_count)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	// Instruction memory content is the address xor a fixed pattern.
	function automatic word_t mem_word(input addr_t addr);
		return addr ^ 32'h5a5a_0000;
	endfunction

	task automatic take_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			if (lfsr[0]) begin
				value = value + (1 << i);
			end
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic wait_reset_release();
		for (int n = 0; n < TIMEOUT; n++) begin
			@(negedge clock);
			if (!reset) begin
				return;
			end
		end
		hung = 1'b1;
		errors++;
		$display("Reset was still high after %0d cycles.", TIMEOUT);
	endtask

	task automatic wait_fetch(output addr_t addr, output word_t word, output logic ok);
		ok = 1'b0;
		addr = '0;
		word = '0;
		if (hung) begin
			return;
		end
		for (int n = 0; n < TIMEOUT; n++) begin
			@(negedge clock);
			if (fetch.valid) begin
				addr = fetch.addr;
				word = fetch.word;
				ok = 1'b1;
				return;
			end
		end
		hung = 1'b1;
		errors++;
		$display("No fetch output within %0d cycles, at time %0t.", TIMEOUT, $time);
	endtask

	task automatic expect_fetch(input addr_t exp_addr);
		addr_t addr;
		word_t word;
		logic ok;
		wait_fetch(addr, word, ok);
		if (!ok) begin
			return;
		end
		checks += 2;
		if (addr != exp_addr) begin
			errors++;
			$display("[FAIL] %0t: fetch address %h, expected %h", $time, addr, exp_addr);
		end
		if (word != mem_word(exp_addr)) begin
			errors++;
			$display("[FAIL] %0t: word %h at %h, expected %h", $time, word, exp_addr,
				mem_word(exp_addr));
		end
	endtask

	task automatic expect_acks(input logic [31:0] expected);
		checks++;
		if (ack_count != expected) begin
			errors++;
			$display("[FAIL] %0t: ack count %0d, expected %0d", $time, ack_count, expected);
		end
	endtask

	// Stall right after an output so no further refill starts.
	task automatic park();
		stall = 1'b1;
		repeat (2) @(negedge clock);
	endtask

	task automatic redirect_to(input addr_t target);
		redirect = '{valid: 1'b1, target: target};
		@(negedge clock);
		redirect = '{valid: 1'b0, target: 32'h0000_0000};
		stall = 1'b0;
	endtask

	task automatic finish_test(input string name, input int start_errors);
		tests++;
		if (errors == start_errors) begin
			$display("%s: passed", name);
		end else begin
			$display("%s: %0d errors", name, errors - start_errors);
		end
	endtask

	task automatic cold_sequential_fetch();
		int start_errors;
		logic [31:0] acks;
		start_errors = errors;
		acks = ack_count;
		for (int i = 0; i < 16; i++) begin
			expect_fetch(i * 4);
		end
		park();
		expect_acks(acks + 32'd16);
		finish_test("cold sequential fetch", start_errors);
	endtask

	task automatic warm_hits();
		int start_errors;
		logic [31:0] acks;
		start_errors = errors;
		acks = ack_count;
		redirect_to(32'h0000_0000);
		for (int i = 0; i < 16; i++) begin
			expect_fetch(i * 4);
		end
		park();
		expect_acks(acks);
		finish_test("warm hits", start_errors);
	endtask

	task automatic redirect_and_continue();
		int start_errors;
		addr_t target;
		start_errors = errors;
		target = 32'h0000_2040;
		redirect_to(target);
		for (int i = 0; i < 4; i++) begin
			expect_fetch(target + i * 4);
		end
		park();
		finish_test("redirect", start_errors);
	endtask

	// One round on warm lines, one on cold lines.
	task automatic stall_and_resume();
		int start_errors;
		int hold;
		addr_t base;
		start_errors = errors;
		for (int r = 0; r < 2; r++) begin
			base = (r == 0) ? 32'h0000_0010 : 32'h0000_3000;
			redirect_to(base);
			for (int i = 0; i < 4; i++) begin
				expect_fetch(base + i * 4);
			end
			take_bits(4, hold);
			stall = 1'b1;
			for (int c = 0; c <= hold; c++) begin
				@(negedge clock);
				checks++;
				if (fetch.valid) begin
					errors++;
					$display("[FAIL] %0t: fetch output valid during stall", $time);
				end
			end
			stall = 1'b0;
			for (int i = 4; i < 8; i++) begin
				expect_fetch(base + i * 4);
			end
			park();
		end
		finish_test("stall", start_errors);
	endtask

	// Both targets share an index with different tags, so each visit evicts the other.
	task automatic conflict_eviction();
		int start_errors;
		logic [31:0] acks;
		addr_t target;
		start_errors = errors;
		for (int k = 0; k < 4; k++) begin
			target = (k % 2 == 0) ? 32'h0000_4008 : 32'h0000_4048;
			acks = ack_count;
			redirect_to(target);
			expect_fetch(target);
			park();
			expect_acks(acks + 32'd1);
		end
		finish_test("conflict eviction", start_errors);
	endtask

	initial begin
		stall = 1'b0;
		redirect = '{valid: 1'b0, target: 32'h0000_0000};
		lfsr = 32'hc2e5_c373;
		hung = 1'b0;
		errors = 0;
		checks = 0;
		tests = 0;
		wait_reset_release();
		cold_sequential_fetch();
		warm_hits();
		redirect_and_continue();
		stall_and_resume();
		conflict_eviction();
		errors += i_cpu_fetch_top.i_cpu_fetch_props.failures;
		$display("Tests %0d, checks %0d, errors %0d.", tests, checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
cpu_types_pkg.sv
wb_bus_pkg.sv
fetch_pc_unit.sv
icache.sv
wb_fetch_master.sv
cpu_fetch_top.sv
tb_clock_gen.sv
tb_wb_memory.sv
cpu_fetch_props.sv
tb_cpu_fetch_top.sv
